//--- bench/nbody_tb.sv
// Drives the bus one strobe at a time and reads x/y only between runs while the memories are idle
`timescale 1ns/1ps
`default_nettype none
`include "nbody_settings.svh"

module nbody_tb;
  import nbody_pkg::*;

  localparam int POLL_LIMIT = 200;
  localparam int RB = `NBODY_REGION_BITS;

  logic                          clk;
  logic                          rst;
  logic                          chipselect_i;
  logic                          write_i;
  logic                          read_i;
  logic [`NBODY_ADDR_WIDTH-1:0]  addr_i;
  logic [`NBODY_EXT_WIDTH-1:0]   writedata_i;
  logic [`NBODY_EXT_WIDTH-1:0]   readdata_o;

  // ==================================================
  // Operation table and reference model
  // ==================================================
  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT} op_kind_e;

  op_kind_e                     op_kind_q [$];
  logic [`NBODY_ADDR_WIDTH-1:0] op_addr_q [$];
  logic [`NBODY_EXT_WIDTH-1:0]  op_data_q [$];
  string                        op_name_q [$];

  // Body values as software expects them
  logic [63:0] model_x  [512];
  logic [63:0] model_y  [512];
  logic [63:0] model_vx [512];
  logic [63:0] model_vy [512];

  logic [31:0] lfsr_q;
  int          errors;
  int          timeouts;

  nbody_top UUT (
    .clk          (clk),
    .rst          (rst),
    .chipselect_i (chipselect_i),
    .write_i      (write_i),
    .read_i       (read_i),
    .addr_i       (addr_i),
    .writedata_i  (writedata_i),
    .readdata_o   (readdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Right-shift Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_word(output logic [63:0] v);
    for (int b = 0; b < 64; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v[b]   = lfsr_q[0];
    end
  endtask

  function automatic logic [`NBODY_ADDR_WIDTH-1:0] make_addr(input logic [RB-1:0] r,
                                                             input int idx);
    return {r, body_idx_t'(idx)};
  endfunction

  // ==================================================
  // Table builders
  // ==================================================
  task automatic add_write(input logic [RB-1:0] r, input int idx, input logic [31:0] d);
    op_kind_q.push_back(OP_WRITE);
    op_addr_q.push_back(make_addr(r, idx));
    op_data_q.push_back(d);
    op_name_q.push_back("write");
  endtask

  task automatic add_read(input logic [RB-1:0] r, input int idx, input logic [31:0] e,
                          input string name);
    op_kind_q.push_back(OP_READ);
    op_addr_q.push_back(make_addr(r, idx));
    op_data_q.push_back(e);
    op_name_q.push_back(name);
  endtask

  // Low word goes first and the high write commits the value
  task automatic set_pos(input int idx, input logic [63:0] x, input logic [63:0] y);
    add_write(X_LO, idx, x[31:0]);
    add_write(X_HI, idx, x[63:32]);
    add_write(Y_LO, idx, y[31:0]);
    add_write(Y_HI, idx, y[63:32]);
    model_x[idx] = x;
    model_y[idx] = y;
  endtask

  task automatic set_vel(input int idx, input logic [63:0] vx, input logic [63:0] vy);
    add_write(VX_LO, idx, vx[31:0]);
    add_write(VX_HI, idx, vx[63:32]);
    add_write(VY_LO, idx, vy[31:0]);
    add_write(VY_HI, idx, vy[63:32]);
    model_vx[idx] = vx;
    model_vy[idx] = vy;
  endtask

  task automatic check_pos(input int idx, input string tag);
    add_read(RD_X_LO, idx, model_x[idx][31:0],  $sformatf("%s x[%0d] lo", tag, idx));
    add_read(RD_X_HI, idx, model_x[idx][63:32], $sformatf("%s x[%0d] hi", tag, idx));
    add_read(RD_Y_LO, idx, model_y[idx][31:0],  $sformatf("%s y[%0d] lo", tag, idx));
    add_read(RD_Y_HI, idx, model_y[idx][63:32], $sformatf("%s y[%0d] hi", tag, idx));
  endtask

  // Gap passes with fixed velocities add gap times v modulo 2^64
  task automatic expect_run(input int nb, input int gap, input string tag);
    op_kind_q.push_back(OP_WAIT);
    op_addr_q.push_back(make_addr(RD_DONE, 0));
    op_data_q.push_back(32'd1);
    op_name_q.push_back(tag);
    for (int i = 0; i < nb; i++) begin
      model_x[i] = model_x[i] + model_vx[i] * 64'(gap);
      model_y[i] = model_y[i] + model_vy[i] * 64'(gap);
    end
  endtask

  // ==================================================
  // Bus drivers
  // ==================================================
  task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
    @(posedge clk);
    chipselect_i <= 1'b1;
    write_i      <= 1'b1;
    addr_i       <= a;
    writedata_i  <= d;
    @(posedge clk);
    chipselect_i <= 1'b0;
    write_i      <= 1'b0;
  endtask

  // Answer cycle follows the strobe and is sampled mid-cycle
  task automatic bus_read(input logic [15:0] a, output logic [31:0] d);
    @(posedge clk);
    chipselect_i <= 1'b1;
    read_i       <= 1'b1;
    addr_i       <= a;
    @(posedge clk);
    chipselect_i <= 1'b0;
    read_i       <= 1'b0;
    @(negedge clk);
    d = readdata_o;
  endtask

  // Readback must ignore a new address until the next read strobe
  task automatic check_hold(input logic [15:0] a, input logic [31:0] d, input string name);
    @(posedge clk);
    addr_i <= a ^ 16'h0001;
    // Memory sees the new address one edge later
    @(posedge clk);
    @(negedge clk);
    assert (readdata_o === d) else begin
      errors++;
      $display("error %s hold expected %h actual %h", name, d, readdata_o);
    end
  endtask

  task automatic wait_done(input string tag);
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (status[0] !== 1'b1 && polls < POLL_LIMIT) begin
      bus_read(make_addr(RD_DONE, 0), status);
      polls++;
    end
    assert (status[0] === 1'b1) else begin
      timeouts++;
      $display("timeout: run %s did not raise done within %0d polls", tag, polls);
    end
  endtask

  initial begin
    logic [63:0] rx;
    logic [63:0] ry;
    logic [31:0] got;
    rst          = 1'b1;
    chipselect_i = 1'b0;
    write_i      = 1'b0;
    read_i       = 1'b0;
    addr_i       = '0;
    writedata_i  = '0;
    lfsr_q       = 32'h7ef2fa00;
    errors       = 0;
    timeouts     = 0;

    // Idle write and readback of random positions
    for (int i = 0; i < 6; i++) begin
      rand_word(rx);
      rand_word(ry);
      set_pos(i, rx, ry);
    end
    for (int i = 0; i < 6; i++) check_pos(i, "idle_rw");

    // Single pass over five bodies while body 5 stays put
    for (int i = 0; i < 5; i++) begin
      rand_word(rx);
      rand_word(ry);
      set_vel(i, rx, ry);
    end
    add_write(REG_N_BODIES, 0, 32'd5);
    add_write(REG_GAP, 0, 32'd1);
    add_write(REG_GO, 0, 32'd1);
    expect_run(5, 1, "gap1_run");
    for (int i = 0; i < 6; i++) check_pos(i, "gap1_run");

    // Acknowledge clears done and holds off the next start
    add_read(RD_DONE, 0, 32'd1, "done_after_run");
    add_write(REG_READ, 0, 32'd1);
    add_read(RD_DONE, 0, 32'd0, "done_after_ack");

    // Wraparound, low-half carry and negative velocities over four passes
    set_pos(0, 64'hFFFF_FFFF_FFFF_FFF0, 64'h0000_0001_FFFF_FFFE);
    set_vel(0, 64'd7, 64'hFFFF_FFFF_FFFF_FFFD);
    set_pos(1, 64'h7FFF_FFFF_FFFF_FFFE, 64'h8000_0000_0000_0003);
    set_vel(1, 64'd1, 64'hFFFF_FFFF_0000_0000);
    for (int i = 2; i < 4; i++) begin
      rand_word(rx);
      rand_word(ry);
      set_pos(i, rx, ry);
      set_vel(i, -(rx & 64'hFFFF_FFFF), -(ry >> 20));
    end
    add_write(REG_N_BODIES, 0, 32'd4);
    add_write(REG_GAP, 0, 32'd4);
    add_write(REG_READ, 0, 32'd0);
    expect_run(4, 4, "gap4_run");
    for (int i = 0; i < 5; i++) check_pos(i, "gap4_run");

    // With go still 1 an ack and then a release restarts the run
    add_write(REG_READ, 0, 32'd1);
    add_write(REG_READ, 0, 32'd0);
    expect_run(4, 4, "rerun");
    for (int i = 0; i < 4; i++) check_pos(i, "rerun");

    // Register map edges
    add_read(7'h00, 0, 32'hFFFF_FFFF, "unmapped_zero");
    add_read(7'h7f, 3, 32'hFFFF_FFFF, "unmapped_top");
    add_read(REG_GO, 0, 32'hFFFF_FFFF, "ctrl_region_read");
    add_write(REG_READ, 0, 32'd1);
    add_write(REG_N_BODIES, 0, 32'd1);
    add_write(REG_GAP, 0, 32'd2);
    add_write(REG_READ, 0, 32'd0);
    expect_run(1, 2, "single_body");
    for (int i = 0; i < 2; i++) check_pos(i, "single_body");

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Readback starts out cleared
    @(negedge clk);
    assert (readdata_o === '0) else begin
      errors++;
      $display("error reset_readdata expected %h actual %h", 32'h0, readdata_o);
    end

    // ==================================================
    // Apply the table
    // ==================================================
    for (int i = 0; i < op_kind_q.size() && timeouts == 0; i++) begin
      case (op_kind_q[i])
        OP_WRITE: bus_write(op_addr_q[i], op_data_q[i]);
        OP_READ: begin
          bus_read(op_addr_q[i], got);
          assert (got === op_data_q[i]) else begin
            errors++;
            $display("error %s expected %h actual %h", op_name_q[i], op_data_q[i], got);
          end
          check_hold(op_addr_q[i], got, op_name_q[i]);
        end
        default: wait_done(op_name_q[i]);
      endcase
    end

    $display("summary: %0d mismatches, %0d timeouts, %0d operations",
             errors, timeouts, op_kind_q.size());
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- nbody_top.f
+incdir+source
source/nbody_pkg.sv
source/body_mem.sv
source/nbody_bus_regs.sv
source/nbody_sequencer.sv
source/position_adder.sv
source/nbody_top.sv
bench/nbody_tb.sv

//--- source/body_mem.sv
// Read data appears one cycle after the address and a same-address write returns the old value
`timescale 1ns/1ps
`default_nettype none

module body_mem #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 512
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  // ==================================================
  // Storage
  // ==================================================
  logic [WIDTH-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Registered read port
  // Reads every cycle so the address must be steered one cycle ahead
  always_ff @(posedge clk) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

//--- source/nbody_bus_regs.sv
// Single-cycle strobes with no wait states; x/y readback is only valid while no run is active
`timescale 1ns/1ps
`default_nettype none
`include "nbody_settings.svh"

module nbody_bus_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          chipselect_i,
  input  logic                          write_i,
  input  logic                          read_i,
  input  logic [`NBODY_ADDR_WIDTH-1:0]  addr_i,
  input  logic [`NBODY_EXT_WIDTH-1:0]   writedata_i,
  input  logic                          busy_i,
  input  logic                          done_i,
  input  nbody_pkg::word_t              x_rd_i,
  input  nbody_pkg::word_t              y_rd_i,
  output logic [`NBODY_EXT_WIDTH-1:0]   readdata_o,
  output logic                          go_o,
  output logic                          read_ack_o,
  output nbody_pkg::body_idx_t          num_bodies_o,
  output logic [`NBODY_EXT_WIDTH-1:0]   gap_o,
  output nbody_pkg::word_t              bus_wdata_o,
  output nbody_pkg::body_idx_t          bus_idx_o,
  output logic                          we_x_o,
  output logic                          we_y_o,
  output logic                          we_vx_o,
  output logic                          we_vy_o
);
  import nbody_pkg::*;

  localparam int EW = `NBODY_EXT_WIDTH;

  logic          wr_stb;
  logic          rd_stb;
  logic          wr_mem;
  region_e       region;
  logic [EW-1:0] lo_q;
  region_e       rd_region_q;
  logic          rd_pend_q;
  logic [EW-1:0] rd_mux;
  logic [EW-1:0] hold_q;

  // ==================================================
  // Address decode
  // ==================================================
  assign wr_stb    = chipselect_i & write_i;
  assign rd_stb    = chipselect_i & read_i;
  // Region sits above the body index
  assign region    = region_e'(addr_i[`NBODY_ADDR_WIDTH-1 -: `NBODY_REGION_BITS]);
  assign bus_idx_o = addr_i[`NBODY_BODY_BITS-1:0];

  // Control registers
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      go_o         <= 1'b0;
      read_ack_o   <= 1'b0;
      num_bodies_o <= '0;
      gap_o        <= '0;
    end else if (wr_stb) begin
      case (region)
        REG_GO:       go_o         <= writedata_i[0];
        REG_READ:     read_ack_o   <= writedata_i[0];
        REG_N_BODIES: num_bodies_o <= writedata_i[`NBODY_BODY_BITS-1:0];
        REG_GAP:      gap_o        <= writedata_i;
        default:      ;
      endcase
    end
  end

  // Low word waits here until the matching high write
  always_ff @(posedge clk) begin
    if (wr_stb && (region inside {X_LO, Y_LO, VX_LO, VY_LO})) begin
      lo_q <= writedata_i;
    end
  end

  // High write completes the 64-bit value
  assign bus_wdata_o = {writedata_i, lo_q};

  // ==================================================
  // Memory write enables
  // ==================================================
  // Locked out while the sequencer owns the memories
  assign wr_mem  = wr_stb & ~busy_i;
  assign we_x_o  = wr_mem & (region == X_HI);
  assign we_y_o  = wr_mem & (region == Y_HI);
  assign we_vx_o = wr_mem & (region == VX_HI);
  assign we_vy_o = wr_mem & (region == VY_HI);

  // ==================================================
  // Readback
  // ==================================================
  // Memory answers one cycle after the strobe so the region follows it
  always_ff @(posedge clk) begin
    if (rd_stb) begin
      rd_region_q <= region;
    end
  end

  // Pick the half or the status word
  always_comb begin
    case (rd_region_q)
      RD_DONE: rd_mux = {{(EW-1){1'b0}}, done_i};
      RD_X_LO: rd_mux = x_rd_i[EW-1:0];
      RD_X_HI: rd_mux = x_rd_i[2*EW-1:EW];
      RD_Y_LO: rd_mux = y_rd_i[EW-1:0];
      RD_Y_HI: rd_mux = y_rd_i[2*EW-1:EW];
      // Unmapped read region
      default: rd_mux = {EW{1'b1}};
    endcase
  end

  // Pending flag marks the answer cycle, hold keeps it afterwards
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_pend_q <= 1'b0;
      hold_q    <= '0;
    end else begin
      rd_pend_q <= rd_stb;
      if (rd_pend_q) begin
        hold_q <= rd_mux;
      end
    end
  end

  assign readdata_o = rd_pend_q ? rd_mux : hold_q;

endmodule

`default_nettype wire

//--- source/nbody_pkg.sv
// Region codes assume a 16-bit address with the body index in the low 9 bits
`default_nettype none
`include "nbody_settings.svh"

package nbody_pkg;

  // ==================================================
  // Bus region codes held in address bits 15..9
  // ==================================================
  typedef enum logic [`NBODY_REGION_BITS-1:0] {
    REG_GO       = 7'h40,
    REG_READ     = 7'h41,
    REG_N_BODIES = 7'h42,
    REG_GAP      = 7'h43,
    X_LO         = 7'h44,
    X_HI         = 7'h45,
    Y_LO         = 7'h46,
    Y_HI         = 7'h47,
    VX_LO        = 7'h4a,
    VX_HI        = 7'h4b,
    VY_LO        = 7'h4c,
    VY_HI        = 7'h4d,
    RD_DONE      = 7'h50,
    RD_X_LO      = 7'h51,
    RD_X_HI      = 7'h52,
    RD_Y_LO      = 7'h53,
    RD_Y_HI      = 7'h54
  } region_e;

  // Run control FSM
  typedef enum logic [1:0] {
    S_IDLE,
    S_PASS,
    S_DRAIN
  } run_state_e;

  // Body index and body value
  typedef logic [`NBODY_BODY_BITS-1:0]  body_idx_t;
  typedef logic [`NBODY_DATA_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

//--- source/nbody_sequencer.sv
// num_bodies and gap must be nonzero and stay stable during a run; done clears only on a read ack
`timescale 1ns/1ps
`default_nettype none
`include "nbody_settings.svh"

module nbody_sequencer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         go_i,
  input  logic                         read_ack_i,
  input  nbody_pkg::body_idx_t         num_bodies_i,
  input  logic [`NBODY_EXT_WIDTH-1:0]  gap_i,
  input  logic                         wb_valid_i,
  output logic                         busy_o,
  output logic                         done_o,
  output nbody_pkg::body_idx_t         rd_idx_o,
  output logic                         rd_valid_o
);
  import nbody_pkg::*;

  run_state_e                   state_q;
  body_idx_t                    rd_idx_q;
  body_idx_t                    wb_cnt_q;
  body_idx_t                    last_idx;
  logic [`NBODY_EXT_WIDTH-1:0]  pass_cnt_q;
  logic                         done_q;
  logic                         start;
  logic                         last_rd;
  logic                         last_wb;
  logic                         last_pass;

  // ==================================================
  // Terminal conditions
  // ==================================================
  assign last_idx  = num_bodies_i - 1'b1;
  assign last_rd   = (rd_idx_q == last_idx);
  // Final writeback of the current pass
  assign last_wb   = wb_valid_i && (wb_cnt_q == last_idx);
  assign last_pass = (pass_cnt_q == gap_i - 1'b1);

  // Handshake allows a start only once done has been acknowledged
  assign start = go_i & ~read_ack_i & ~done_q;

  // ==================================================
  // Run FSM
  // ==================================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= S_IDLE;
      rd_idx_q   <= '0;
      wb_cnt_q   <= '0;
      pass_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // Software acknowledges the result
          if (read_ack_i) begin
            done_q <= 1'b0;
          end
          if (start) begin
            state_q    <= S_PASS;
            rd_idx_q   <= '0;
            wb_cnt_q   <= '0;
            pass_cnt_q <= '0;
          end
        end
        S_PASS: begin
          // Early bodies can return before the last read goes out
          if (wb_valid_i) begin
            wb_cnt_q <= wb_cnt_q + 1'b1;
          end
          if (!go_i) begin
            state_q <= S_IDLE;
          end else if (last_rd) begin
            state_q <= S_DRAIN;
          end else begin
            rd_idx_q <= rd_idx_q + 1'b1;
          end
        end
        S_DRAIN: begin
          if (wb_valid_i) begin
            wb_cnt_q <= wb_cnt_q + 1'b1;
          end
          if (!go_i) begin
            state_q <= S_IDLE;
          end else if (last_wb) begin
            if (last_pass) begin
              // All gap passes finished
              done_q  <= 1'b1;
              state_q <= S_IDLE;
            end else begin
              // Next pass reads the fresh positions
              pass_cnt_q <= pass_cnt_q + 1'b1;
              rd_idx_q   <= '0;
              wb_cnt_q   <= '0;
              state_q    <= S_PASS;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Outputs
  assign busy_o     = (state_q != S_IDLE);
  assign done_o     = done_q;
  assign rd_idx_o   = rd_idx_q;
  assign rd_valid_o = (state_q == S_PASS);

endmodule

`default_nettype wire

//--- source/nbody_settings.svh
// Widths are fixed at build time and the 16-bit address split must keep 7 region bits plus 9 index bits
`ifndef NBODY_SETTINGS_SVH
`define NBODY_SETTINGS_SVH

// ==================================================
// Bus side
// ==================================================
// Avalon-style data word
`define NBODY_EXT_WIDTH 32
// Word address seen by the bus slave
`define NBODY_ADDR_WIDTH 16
// Region code in the top address bits
`define NBODY_REGION_BITS 7

// ==================================================
// Body storage
// ==================================================
// One body value spans two bus words
`define NBODY_DATA_WIDTH 64
// Body index width, up to 512 bodies
`define NBODY_BODY_BITS 9

`endif

//--- source/nbody_top.sv
// Bus x/y reads and memory writes are steered away from software while a run is busy
`timescale 1ns/1ps
`default_nettype none
`include "nbody_settings.svh"

module nbody_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          chipselect_i,
  input  logic                          write_i,
  input  logic                          read_i,
  input  logic [`NBODY_ADDR_WIDTH-1:0]  addr_i,
  input  logic [`NBODY_EXT_WIDTH-1:0]   writedata_i,
  output logic [`NBODY_EXT_WIDTH-1:0]   readdata_o
);
  import nbody_pkg::*;

  localparam int DEPTH = 1 << `NBODY_BODY_BITS;

  logic                         go;
  logic                         read_ack;
  logic                         busy;
  logic                         done;
  logic                         rd_valid;
  logic                         wb_valid;
  logic                         mem_valid_q;
  logic [`NBODY_EXT_WIDTH-1:0]  gap;
  body_idx_t                    num_bodies;
  body_idx_t                    rd_idx;
  body_idx_t                    wb_idx;
  body_idx_t                    bus_idx;
  body_idx_t                    mem_idx_q;
  body_idx_t                    raddr;
  body_idx_t                    xy_waddr;
  word_t                        bus_wdata;
  word_t                        x_rd;
  word_t                        y_rd;
  word_t                        vx_rd;
  word_t                        vy_rd;
  word_t                        sum_x;
  word_t                        sum_y;
  word_t                        x_wdata;
  word_t                        y_wdata;
  logic                         we_x;
  logic                         we_y;
  logic                         we_vx;
  logic                         we_vy;
  logic                         x_we;
  logic                         y_we;

  // ==================================================
  // Bus slave and run control
  // ==================================================
  nbody_bus_regs u_bus_regs (
    .clk          (clk),
    .rst          (rst),
    .chipselect_i (chipselect_i),
    .write_i      (write_i),
    .read_i       (read_i),
    .addr_i       (addr_i),
    .writedata_i  (writedata_i),
    .busy_i       (busy),
    .done_i       (done),
    .x_rd_i       (x_rd),
    .y_rd_i       (y_rd),
    .readdata_o   (readdata_o),
    .go_o         (go),
    .read_ack_o   (read_ack),
    .num_bodies_o (num_bodies),
    .gap_o        (gap),
    .bus_wdata_o  (bus_wdata),
    .bus_idx_o    (bus_idx),
    .we_x_o       (we_x),
    .we_y_o       (we_y),
    .we_vx_o      (we_vx),
    .we_vy_o      (we_vy)
  );

  nbody_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .go_i         (go),
    .read_ack_i   (read_ack),
    .num_bodies_i (num_bodies),
    .gap_i        (gap),
    .wb_valid_i   (wb_valid),
    .busy_o       (busy),
    .done_o       (done),
    .rd_idx_o     (rd_idx),
    .rd_valid_o   (rd_valid)
  );

  // ==================================================
  // Memory port steering
  // ==================================================
  // Run owns the read address and the x/y write port
  assign raddr    = busy ? rd_idx    : bus_idx;
  assign xy_waddr = busy ? wb_idx    : bus_idx;
  assign x_we     = busy ? wb_valid  : we_x;
  assign y_we     = busy ? wb_valid  : we_y;
  assign x_wdata  = busy ? sum_x     : bus_wdata;
  assign y_wdata  = busy ? sum_y     : bus_wdata;

  body_mem #(.WIDTH(`NBODY_DATA_WIDTH), .DEPTH(DEPTH)) u_mem_x (
    .clk (clk), .we_i (x_we), .waddr_i (xy_waddr), .wdata_i (x_wdata),
    .raddr_i (raddr), .rdata_o (x_rd)
  );
  body_mem #(.WIDTH(`NBODY_DATA_WIDTH), .DEPTH(DEPTH)) u_mem_y (
    .clk (clk), .we_i (y_we), .waddr_i (xy_waddr), .wdata_i (y_wdata),
    .raddr_i (raddr), .rdata_o (y_rd)
  );
  // Velocities are only ever written from the bus
  body_mem #(.WIDTH(`NBODY_DATA_WIDTH), .DEPTH(DEPTH)) u_mem_vx (
    .clk (clk), .we_i (we_vx), .waddr_i (bus_idx), .wdata_i (bus_wdata),
    .raddr_i (raddr), .rdata_o (vx_rd)
  );
  body_mem #(.WIDTH(`NBODY_DATA_WIDTH), .DEPTH(DEPTH)) u_mem_vy (
    .clk (clk), .we_i (we_vy), .waddr_i (bus_idx), .wdata_i (bus_wdata),
    .raddr_i (raddr), .rdata_o (vy_rd)
  );

  // Match the one-cycle memory read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_valid_q <= 1'b0;
    end else begin
      mem_valid_q <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    mem_idx_q <= rd_idx;
  end

  // Writeback lands three cycles after its read
  position_adder u_adder (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (mem_valid_q),
    .idx_i      (mem_idx_q),
    .x_i        (x_rd),
    .y_i        (y_rd),
    .vx_i       (vx_rd),
    .vy_i       (vy_rd),
    .wb_valid_o (wb_valid),
    .wb_idx_o   (wb_idx),
    .sum_x_o    (sum_x),
    .sum_y_o    (sum_y)
  );

endmodule

`default_nettype wire

//--- source/position_adder.sv
// Two-cycle latency with one body accepted per cycle; sums wrap modulo 2^64
`timescale 1ns/1ps
`default_nettype none
`include "nbody_settings.svh"

module position_adder (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  valid_i,
  input  nbody_pkg::body_idx_t  idx_i,
  input  nbody_pkg::word_t      x_i,
  input  nbody_pkg::word_t      y_i,
  input  nbody_pkg::word_t      vx_i,
  input  nbody_pkg::word_t      vy_i,
  output logic                  wb_valid_o,
  output nbody_pkg::body_idx_t  wb_idx_o,
  output nbody_pkg::word_t      sum_x_o,
  output nbody_pkg::word_t      sum_y_o
);
  import nbody_pkg::*;

  localparam int HALF = `NBODY_DATA_WIDTH / 2;

  // Lane 0 is x and lane 1 is y
  word_t           pos [2];
  word_t           vel [2];
  logic [HALF:0]   lo_sum [2];
  logic [HALF-1:0] lo_q [2];
  logic            carry_q [2];
  logic [HALF-1:0] pos_hi_q [2];
  logic [HALF-1:0] vel_hi_q [2];
  word_t           sum_q [2];
  logic            valid_q;
  body_idx_t       idx_q;

  assign pos[0] = x_i;
  assign pos[1] = y_i;
  assign vel[0] = vx_i;
  assign vel[1] = vy_i;

  // ==================================================
  // Stage 1 adds low halves and keeps the carry
  // ==================================================
  always_comb begin
    for (int l = 0; l < 2; l++) begin
      lo_sum[l] = {1'b0, pos[l][HALF-1:0]} + {1'b0, vel[l][HALF-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < 2; l++) begin
      lo_q[l]     <= lo_sum[l][HALF-1:0];
      carry_q[l]  <= lo_sum[l][HALF];
      pos_hi_q[l] <= pos[l][2*HALF-1:HALF];
      vel_hi_q[l] <= vel[l][2*HALF-1:HALF];
    end
    // Stage 2 adds high halves with the carry and drops the carry out
    for (int l = 0; l < 2; l++) begin
      sum_q[l] <= {pos_hi_q[l] + vel_hi_q[l] + carry_q[l], lo_q[l]};
    end
  end

  // Index rides beside the data
  always_ff @(posedge clk) begin
    idx_q    <= idx_i;
    wb_idx_o <= idx_q;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q    <= 1'b0;
      wb_valid_o <= 1'b0;
    end else begin
      valid_q    <= valid_i;
      wb_valid_o <= valid_q;
    end
  end

  assign sum_x_o = sum_q[0];
  assign sum_y_o = sum_q[1];

endmodule

`default_nettype wire
